//--- design/rob_settings.svh
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// Buffer depth must be a power of two
`define ROB_DEPTH 8
`define ROB_IDX_W $clog2(`ROB_DEPTH)

`define NUM_SRCS 2
`define NUM_AREGS 32
`define AREG_W $clog2(`NUM_AREGS)

`define DATA_W 32
`define SIMID_W 32

`endif

//--- design/rob_pkg.sv
`include "rob_settings.svh"

package rob_pkg;

   typedef enum logic {
      OP_ALU,
      OP_BRANCH
   } t_opclass;

   typedef logic [`AREG_W-1:0] t_areg;
   typedef logic [`DATA_W-1:0] t_data;

   // Wrap bit separates full from empty
   typedef struct packed {
      logic wrap;
      logic [`ROB_IDX_W-1:0] idx;
   } t_rob_id;

   typedef struct packed {
      t_opclass opclass;
      logic wr_reg;
      t_areg dst;
      t_areg [`NUM_SRCS-1:0] src;
      logic [`SIMID_W-1:0] simid;   // Debug tag only
   } t_uinstr;

   typedef struct packed {
      t_rob_id robid;
      t_data data;                  // Branch target for branches
      logic mispred;
   } t_rob_result;

   typedef struct packed {
      logic valid;
      logic ready;
      t_uinstr uinstr;
      t_data data;
      logic mispred;
   } t_rob_ent;

endpackage

//--- design/rob_ifs.sv
`timescale 1ns/10ps

interface rob_alloc_if
   import rob_pkg::*;
();
   logic alloc_valid;
   t_uinstr alloc_uinstr;
   t_rob_id alloc_robid;   // Tail id
   logic rob_full;

   modport producer (output alloc_valid, output alloc_uinstr,
                     input alloc_robid, input rob_full);
   modport buffer (input alloc_valid, input alloc_uinstr,
                   output alloc_robid, output rob_full);
endinterface

interface rob_retire_if
   import rob_pkg::*;
();
   logic head_valid;   // Head valid and ready
   t_uinstr head_uinstr;
   t_data head_data;
   logic head_mispred;
   t_rob_id head_robid;
   logic flush;

   modport buffer (output head_valid, output head_uinstr, output head_data,
                   output head_mispred, output head_robid, input flush);
   modport consumer (input head_valid, input head_uinstr, input head_data,
                     input head_mispred, input head_robid, output flush);
endinterface

//--- design/dispatch_stage.sv
`timescale 1ns/10ps
`include "rob_settings.svh"

module dispatch_stage
   import rob_pkg::*;
(
   input logic clk,
   input logic reset,

   input logic dec_valid,
   input t_uinstr dec_uinstr,
   output logic dec_ready,
   output t_rob_id dispatch_robid,
   output logic src_pending [`NUM_SRCS],
   output t_rob_id src_robid [`NUM_SRCS],

   rob_alloc_if.producer alloc,
   input logic flush,

   output t_areg lookup_reg [`NUM_SRCS],
   input logic lookup_pending [`NUM_SRCS],
   input t_rob_id lookup_robid [`NUM_SRCS]
);

   localparam int CNT_W = 8;

   logic [CNT_W-1:0] disp_cnt;   // Saturating count of dispatches since last flush
   logic fire;
   logic report_deps;

   // Hold off while full or while a branch flush retires
   assign dec_ready = ~alloc.rob_full & ~flush;
   assign fire = dec_valid & dec_ready;

   assign alloc.alloc_valid = fire;
   assign alloc.alloc_uinstr = dec_uinstr;

   assign dispatch_robid = alloc.alloc_robid;

   always_ff @(posedge clk) begin
      if (reset) begin
         disp_cnt <= '0;
      end else if (flush) begin
         disp_cnt <= '0;
      end else if (fire && disp_cnt != '1) begin
         disp_cnt <= disp_cnt + 1'b1;
      end
   end

   // Nothing can be in flight if nothing went out since the flush
   assign report_deps = ~flush & (disp_cnt != '0);

   always_comb begin
      for (int s = 0; s < `NUM_SRCS; s++) begin
         lookup_reg[s] = dec_uinstr.src[s];
         src_pending[s] = report_deps & lookup_pending[s];
         src_robid[s] = src_pending[s] ? lookup_robid[s] : '0;
      end
   end

endmodule

//--- design/reorder_buffer.sv
`timescale 1ns/10ps
`include "rob_settings.svh"

module reorder_buffer
   import rob_pkg::*;
(
   input logic clk,
   input logic reset,

   rob_alloc_if.buffer alloc,
   rob_retire_if.buffer retire,

   input logic cmp_valid,
   input t_rob_result cmp_result,

   input t_areg lookup_reg [`NUM_SRCS],
   output logic lookup_pending [`NUM_SRCS],
   output t_rob_id lookup_robid [`NUM_SRCS]
);

   t_rob_ent ents [`ROB_DEPTH];
   t_rob_id head;   // Oldest entry
   t_rob_id tail;   // Next free slot
   t_rob_id head_nxt;
   t_rob_id tail_nxt;
   t_rob_ent head_ent;
   logic rob_full;
   logic retire_now;
   logic cmp_hit;

   function automatic t_rob_id incr_id(input t_rob_id id);
      return t_rob_id'({id.wrap, id.idx} + 1'b1);
   endfunction

   assign head_nxt = incr_id(head);
   assign tail_nxt = incr_id(tail);

   assign rob_full = (head.idx == tail.idx) && (head.wrap != tail.wrap);

   assign alloc.rob_full = rob_full;
   assign alloc.alloc_robid = tail;

   assign head_ent = ents[head.idx];

   // Valid bit alone covers the empty case
   assign retire.head_valid = head_ent.valid & head_ent.ready;
   assign retire.head_uinstr = head_ent.uinstr;
   assign retire.head_data = head_ent.data;
   assign retire.head_mispred = head_ent.mispred;
   assign retire.head_robid = head;

   assign retire_now = retire.head_valid;
   assign cmp_hit = cmp_valid & ents[cmp_result.robid.idx].valid;   // Drop stale ids

   always_ff @(posedge clk) begin
      if (reset) begin
         head <= '0;
         tail <= '0;
         for (int i = 0; i < `ROB_DEPTH; i++) begin
            ents[i].valid <= 1'b0;
            ents[i].ready <= 1'b0;
         end
      end else if (retire.flush) begin
         // Branch retires and takes everything younger with it
         for (int i = 0; i < `ROB_DEPTH; i++) begin
            ents[i].valid <= 1'b0;
         end
         head <= head_nxt;
         tail <= head_nxt;
      end else begin
         if (retire_now) begin
            ents[head.idx].valid <= 1'b0;
            head <= head_nxt;
         end
         if (alloc.alloc_valid) begin
            ents[tail.idx].valid <= 1'b1;
            ents[tail.idx].ready <= 1'b0;
            ents[tail.idx].uinstr <= alloc.alloc_uinstr;
            tail <= tail_nxt;
         end
         if (cmp_hit) begin
            ents[cmp_result.robid.idx].ready <= 1'b1;
            ents[cmp_result.robid.idx].data <= cmp_result.data;
            ents[cmp_result.robid.idx].mispred <= cmp_result.mispred;
         end
      end
   end

   // Walk back from the tail to find the youngest in-flight writer
   always_comb begin
      logic [`ROB_IDX_W:0] cand;
      t_rob_ent ent;
      for (int s = 0; s < `NUM_SRCS; s++) begin
         lookup_pending[s] = 1'b0;
         lookup_robid[s] = '0;
         for (int k = 1; k <= `ROB_DEPTH; k++) begin
            cand = {tail.wrap, tail.idx} - (`ROB_IDX_W+1)'(k);
            ent = ents[cand[`ROB_IDX_W-1:0]];
            if (!lookup_pending[s] && ent.valid && ent.uinstr.wr_reg &&
                ent.uinstr.dst != '0 && ent.uinstr.dst == lookup_reg[s]) begin
               lookup_pending[s] = 1'b1;
               lookup_robid[s] = t_rob_id'(cand);   // Keeps the wrap bit
            end
         end
      end
   end

endmodule

//--- design/retire_unit.sv
`timescale 1ns/10ps
`include "rob_settings.svh"

module retire_unit
   import rob_pkg::*;
(
   input logic clk,
   input logic reset,

   rob_retire_if.consumer retire,

   input t_areg arch_rd_addr,
   output t_data arch_rd_data,

   output logic ret_valid,
   output t_areg ret_reg,
   output t_data ret_data,
   output t_rob_id ret_robid,
   output logic flush_out,
   output t_data flush_target
);

   t_data arf [`NUM_AREGS];
   logic arf_we;

   assign arf_we = retire.head_valid & retire.head_uinstr.wr_reg;

   // Mispredicted branch at the head flushes in the same cycle
   assign retire.flush = retire.head_valid & retire.head_mispred &
                         (retire.head_uinstr.opclass == OP_BRANCH);

   always_ff @(posedge clk) begin
      if (arf_we && retire.head_uinstr.dst != '0) begin
         arf[retire.head_uinstr.dst] <= retire.head_data;
      end
   end

   assign arch_rd_data = (arch_rd_addr == '0) ? '0 : arf[arch_rd_addr];   // x0 hardwired

   always_ff @(posedge clk) begin
      if (reset) begin
         ret_valid <= 1'b0;
         flush_out <= 1'b0;
      end else begin
         ret_valid <= arf_we;
         flush_out <= retire.flush;
      end
   end

   // Retire and flush report payload
   always_ff @(posedge clk) begin
      ret_reg <= retire.head_uinstr.dst;
      ret_data <= retire.head_data;
      ret_robid <= retire.head_robid;
      flush_target <= retire.head_data;
   end

endmodule

//--- design/rob_core_top.sv
`timescale 1ns/10ps
`include "rob_settings.svh"

module rob_core_top
   import rob_pkg::*;
(
   input logic clk,
   input logic reset,

   input logic dec_valid,
   input t_uinstr dec_uinstr,
   output logic dec_ready,
   output t_rob_id dispatch_robid,
   output logic src_pending [`NUM_SRCS],
   output t_rob_id src_robid [`NUM_SRCS],

   input logic cmp_valid,
   input t_rob_id cmp_robid,
   input t_data cmp_data,
   input logic cmp_mispred,

   input t_areg arch_rd_addr,
   output t_data arch_rd_data,

   output logic ret_valid,
   output t_areg ret_reg,
   output t_data ret_data,
   output t_rob_id ret_robid,
   output logic flush_out,
   output t_data flush_target
);

   rob_alloc_if alloc_if ();
   rob_retire_if retire_if ();

   t_rob_result cmp_result;
   t_areg lookup_reg [`NUM_SRCS];
   logic lookup_pending [`NUM_SRCS];
   t_rob_id lookup_robid [`NUM_SRCS];

   assign cmp_result = '{robid: cmp_robid, data: cmp_data, mispred: cmp_mispred};

   dispatch_stage i_dispatch (
      .clk, .reset,
      .dec_valid, .dec_uinstr, .dec_ready, .dispatch_robid,
      .src_pending, .src_robid,
      .alloc (alloc_if.producer),
      .flush (retire_if.flush),
      .lookup_reg, .lookup_pending, .lookup_robid
   );

   reorder_buffer i_rob (
      .clk, .reset,
      .alloc (alloc_if.buffer),
      .retire (retire_if.buffer),
      .cmp_valid, .cmp_result,
      .lookup_reg, .lookup_pending, .lookup_robid
   );

   retire_unit i_retire (
      .clk, .reset,
      .retire (retire_if.consumer),
      .arch_rd_addr, .arch_rd_data,
      .ret_valid, .ret_reg, .ret_data, .ret_robid,
      .flush_out, .flush_target
   );

endmodule

//--- testbench/rob_assertions.sv
`timescale 1ns/10ps
`include "rob_settings.svh"

module rob_assertions
   import rob_pkg::*;
(
   input logic clk,
   input logic reset,
   input t_rob_id head,
   input t_rob_id tail,
   input logic rob_full,
   input logic alloc_valid,
   input logic flush,
   input t_rob_ent ents [`ROB_DEPTH]
);

   logic [`ROB_IDX_W:0] occupancy;
   logic head_ent_valid;
   logic any_valid;

   assign occupancy = {tail.wrap, tail.idx} - {head.wrap, head.idx};
   assign head_ent_valid = ents[head.idx].valid;

   always_comb begin
      any_valid = 1'b0;
      for (int i = 0; i < `ROB_DEPTH; i++) begin
         any_valid = any_valid | ents[i].valid;
      end
   end

   no_alloc_when_full: assert property (@(posedge clk) disable iff (reset)
      rob_full |-> !alloc_valid)
      else $error("allocation while buffer full");

   occupancy_in_range: assert property (@(posedge clk) disable iff (reset)
      occupancy <= (`ROB_IDX_W+1)'(`ROB_DEPTH))
      else $error("tail ran ahead of head by more than the depth");

   // Head slot holds an entry exactly when the buffer is not empty
   head_valid_tracks_occupancy: assert property (@(posedge clk) disable iff (reset)
      head_ent_valid == (occupancy != '0))
      else $error("head entry valid bit disagrees with pointer distance");

   flush_clears_entries: assert property (@(posedge clk) disable iff (reset)
      flush |=> !any_valid && (head == tail))
      else $error("entry still valid after flush");

endmodule

bind reorder_buffer rob_assertions i_rob_assertions (
   .clk,
   .reset,
   .head,
   .tail,
   .rob_full,
   .alloc_valid (alloc.alloc_valid),
   .flush (retire.flush),
   .ents
);

//--- testbench/rob_tb.sv
`timescale 1ns/10ps
`include "rob_settings.svh"

module rob_tb
   import rob_pkg::*;
();

   localparam int PERIOD = 100;
   localparam int RESET_CYCLES = 10;
   localparam int WAIT_LIMIT = 50;
   localparam int N_INORDER = 6;
   localparam int N_YOUNG = 3;
   // Roughly 12 cycles per micro-op plus register readbacks
   localparam int TEST_CYCLES = RESET_CYCLES + 4 * `NUM_AREGS +
                                12 * (N_INORDER + `ROB_DEPTH + 3 + 2 * N_YOUNG + 2);
   localparam int WATCHDOG_NS = 2 * TEST_CYCLES * PERIOD;

   logic clk;
   logic reset;
   logic dec_valid;
   t_uinstr dec_uinstr;
   logic dec_ready;
   t_rob_id dispatch_robid;
   logic src_pending [`NUM_SRCS];
   t_rob_id src_robid [`NUM_SRCS];
   logic cmp_valid;
   t_rob_id cmp_robid;
   t_data cmp_data;
   logic cmp_mispred;
   t_areg arch_rd_addr;
   t_data arch_rd_data;
   logic ret_valid;
   t_areg ret_reg;
   t_data ret_data;
   t_rob_id ret_robid;
   logic flush_out;
   t_data flush_target;

   // Reference model state
   logic [31:0] rng_state = 32'd31612;
   logic [`ROB_IDX_W:0] exp_tail;
   t_data exp_data [`ROB_DEPTH];
   t_rob_id exp_id_q [$];         // Writers still to retire in program order
   t_areg exp_dst_q [$];
   t_data ref_regs [`NUM_AREGS];
   logic ref_written [`NUM_AREGS];
   logic flush_expected;
   int next_simid;
   t_rob_id got_id;
   logic got_pending [`NUM_SRCS];
   t_rob_id got_src_id [`NUM_SRCS];

   rob_core_top i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      abort("watchdog expired before the tests finished");
   end

   function automatic logic [31:0] xorshift32();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic abort(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         abort($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
      end
   endtask

   // Retire reports must follow program order of the writers
   always @(negedge clk) begin
      if (!reset) begin
         if (flush_out && !flush_expected) begin
            abort("flush_out raised with no mispredicted branch at the head");
         end else if (ret_valid && exp_id_q.size() == 0) begin
            abort("retire reported with no writer left in flight");
         end else if (ret_valid) begin
            check(32'(ret_robid), 32'(exp_id_q[0]), "ret_robid");
            check(32'(ret_reg), 32'(exp_dst_q[0]), "ret_reg");
            check(ret_data, exp_data[exp_id_q[0].idx], "ret_data");
            ref_regs[exp_dst_q[0]] = exp_data[exp_id_q[0].idx];
            ref_written[exp_dst_q[0]] = 1'b1;
            void'(exp_id_q.pop_front());
            void'(exp_dst_q.pop_front());
         end
      end
   end

   task automatic dispatch(input t_opclass op, input logic wr, input t_areg dst,
                           input t_areg s0, input t_areg s1, input logic track);
      int waited;
      waited = 0;
      @(negedge clk);
      dec_valid = 1'b1;
      dec_uinstr.opclass = op;
      dec_uinstr.wr_reg = wr;
      dec_uinstr.dst = dst;
      dec_uinstr.src[0] = s0;
      dec_uinstr.src[1] = s1;
      dec_uinstr.simid = next_simid;
      next_simid++;
      #(PERIOD/4);
      while (!dec_ready) begin
         waited++;
         if (waited > WAIT_LIMIT) abort("dec_ready stayed low, micro-op never accepted");
         @(negedge clk);
         #(PERIOD/4);
      end
      got_id = dispatch_robid;
      for (int s = 0; s < `NUM_SRCS; s++) begin
         got_pending[s] = src_pending[s];
         got_src_id[s] = src_robid[s];
      end
      check(32'(dispatch_robid), 32'(exp_tail), "dispatch_robid");
      if (track && wr) begin
         exp_id_q.push_back(dispatch_robid);
         exp_dst_q.push_back(dst);
      end
      exp_tail = exp_tail + 1'b1;
      @(negedge clk);
      dec_valid = 1'b0;
   endtask

   task automatic complete(input t_rob_id id, input t_data data, input logic mispred);
      @(negedge clk);
      cmp_valid = 1'b1;
      cmp_robid = id;
      cmp_data = data;
      cmp_mispred = mispred;
      exp_data[id.idx] = data;
      @(negedge clk);
      cmp_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_id_q.size() != 0) begin
         waited++;
         if (waited > WAIT_LIMIT) abort("in-flight writers never retired");
         @(negedge clk);
      end
   endtask

   task automatic check_arch_regs();
      for (int r = 0; r < `NUM_AREGS; r++) begin
         @(negedge clk);
         arch_rd_addr = t_areg'(r);
         #(PERIOD/4);
         if (r == 0) check(arch_rd_data, '0, "x0 read");
         else if (ref_written[r]) check(arch_rd_data, ref_regs[r], $sformatf("arch reg %0d", r));
      end
   endtask

   task automatic test_reset_state();
      @(negedge clk);
      #(PERIOD/4);
      check(32'(dec_ready), 32'd1, "dec_ready after reset");
      check(32'(ret_valid), 32'd0, "ret_valid after reset");
      check(32'(flush_out), 32'd0, "flush_out after reset");
      check(32'(dispatch_robid), 32'd0, "dispatch_robid after reset");
   endtask

   task automatic test_in_order_retire();
      t_rob_id ids [N_INORDER];
      int order [N_INORDER];
      int j;
      int tmp;
      for (int i = 0; i < N_INORDER; i++) begin
         dispatch(OP_ALU, 1'b1, t_areg'(1 + xorshift32() % 31), t_areg'(xorshift32()),
                  t_areg'(xorshift32()), 1'b1);
         ids[i] = got_id;
         order[i] = i;
      end
      for (int i = N_INORDER - 1; i > 0; i--) begin   // Fisher-Yates shuffle
         j = int'(xorshift32() % (i + 1));
         tmp = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
      for (int i = 0; i < N_INORDER; i++) complete(ids[order[i]], xorshift32(), 1'b0);
      wait_drain();
      check_arch_regs();
   endtask

   task automatic test_full_backpressure();
      t_rob_id ids [`ROB_DEPTH];
      int waited;
      for (int i = 0; i < `ROB_DEPTH; i++) begin
         dispatch(OP_ALU, 1'b1, t_areg'(1 + xorshift32() % 31), '0, '0, 1'b1);
         ids[i] = got_id;
      end
      @(negedge clk);
      #(PERIOD/4);
      check(32'(dec_ready), 32'd0, "dec_ready with buffer full");
      complete(ids[0], xorshift32(), 1'b0);
      waited = 0;
      while (exp_id_q.size() == `ROB_DEPTH) begin
         waited++;
         if (waited > WAIT_LIMIT) abort("head of a full buffer never retired");
         @(negedge clk);
      end
      #(PERIOD/4);
      check(32'(dec_ready), 32'd1, "dec_ready after head retired");
      for (int i = 1; i < `ROB_DEPTH; i++) complete(ids[i], xorshift32(), 1'b0);
      wait_drain();
   endtask

   task automatic test_dependency_lookup();
      t_areg reg_a;
      t_areg reg_free;
      t_rob_id older;
      t_rob_id younger;
      t_rob_id reader;
      reg_a = t_areg'(1 + xorshift32() % 30);
      reg_free = reg_a + 1'b1;   // Nobody in flight writes it
      dispatch(OP_ALU, 1'b1, reg_a, '0, '0, 1'b1);
      older = got_id;
      dispatch(OP_ALU, 1'b1, reg_a, '0, '0, 1'b1);
      younger = got_id;
      dispatch(OP_ALU, 1'b1, reg_free, reg_a, reg_free, 1'b1);
      reader = got_id;
      check(32'(got_pending[0]), 32'd1, "src 0 pending");
      check(32'(got_src_id[0]), 32'(younger), "src 0 robid");
      check(32'(got_pending[1]), 32'd0, "src 1 pending");
      complete(younger, xorshift32(), 1'b0);
      complete(reader, xorshift32(), 1'b0);
      complete(older, xorshift32(), 1'b0);
      wait_drain();
      check_arch_regs();
   endtask

   task automatic test_mispredict_flush();
      t_rob_id branch_id;
      t_rob_id young_ids [N_YOUNG];
      t_data target;
      t_areg new_dst;
      t_data stale_data;
      int waited;
      dispatch(OP_BRANCH, 1'b0, '0, '0, '0, 1'b0);
      branch_id = got_id;
      for (int k = 0; k < N_YOUNG; k++) begin
         dispatch(OP_ALU, 1'b1, t_areg'(1 + xorshift32() % 31), '0, '0, 1'b0);
         young_ids[k] = got_id;
      end
      for (int k = 0; k < N_YOUNG; k++) complete(young_ids[k], xorshift32(), 1'b0);
      target = xorshift32();
      flush_expected = 1'b1;
      complete(branch_id, target, 1'b1);
      waited = 0;
      while (!flush_out) begin
         waited++;
         if (waited > WAIT_LIMIT) abort("mispredicted branch never raised flush_out");
         @(negedge clk);
      end
      check(flush_target, target, "flush_target");
      @(negedge clk);
      flush_expected = 1'b0;
      exp_tail = {branch_id.wrap, branch_id.idx} + 1'b1;   // Tail restarts after branch
      for (int k = 1; k < N_YOUNG; k++) complete(young_ids[k], xorshift32(), 1'b0);
      new_dst = t_areg'(1 + xorshift32() % 31);
      stale_data = xorshift32();
      // Stale completion lands on the slot being refilled
      fork
         dispatch(OP_ALU, 1'b1, new_dst, '0, '0, 1'b1);
         complete(young_ids[0], stale_data, 1'b0);
      join
      repeat (4) @(negedge clk);
      check(32'(exp_id_q.size()), 32'd1, "writers left after stale completions");
      complete(got_id, xorshift32(), 1'b0);
      wait_drain();
      check_arch_regs();
   endtask

   initial begin
      reset = 1'b1;
      dec_valid = 1'b0;
      dec_uinstr = '0;
      cmp_valid = 1'b0;
      cmp_robid = '0;
      cmp_data = '0;
      cmp_mispred = 1'b0;
      arch_rd_addr = '0;
      exp_tail = '0;
      flush_expected = 1'b0;
      next_simid = 0;
      for (int r = 0; r < `NUM_AREGS; r++) begin
         ref_regs[r] = '0;
         ref_written[r] = 1'b0;
      end
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
      test_reset_state();
      test_in_order_retire();
      test_full_backpressure();
      test_dependency_lookup();
      test_mispredict_flush();
      $display("Test OK");
      $finish;
   end

endmodule

//--- files.f
+incdir+design
design/rob_pkg.sv
design/rob_ifs.sv
design/dispatch_stage.sv
design/reorder_buffer.sv
design/retire_unit.sv
design/rob_core_top.sv
testbench/rob_assertions.sv
testbench/rob_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
TOP        := rob_tb
DUT_TOP    := rob_core_top
FILELIST   := files.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
